//--- Bender.yml
package:
  name: udp_tx

sources:
  - logic/udp_tx_pkg.sv
  - logic/payload_fifo.sv
  - logic/payload_accum.sv
  - logic/header_checksum.sv
  - logic/frame_sequencer.sv
  - logic/udp_tx_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/udp_tx_assertions.sv
      - testbench/tb_udp_tx.sv

//--- project.f
+incdir+testbench
logic/udp_tx_pkg.sv
logic/payload_fifo.sv
logic/payload_accum.sv
logic/header_checksum.sv
logic/frame_sequencer.sv
logic/udp_tx_top.sv
testbench/udp_tx_assertions.sv
testbench/tb_udp_tx.sv

//--- testbench/udp_frame_model.svh
`ifndef UDP_FRAME_MODEL_SVH
`define UDP_FRAME_MODEL_SVH

// Ones-complement sum, folded twice, then inverted
function automatic udp_tx_pkg::csum_t ones_csum(input logic [15:0] halves[$]);
    udp_tx_pkg::sum_t acc;
    acc = '0;
    foreach (halves[i]) begin
        acc = acc + udp_tx_pkg::sum_t'(halves[i]);
    end
    repeat (2) acc = {16'h0000, acc[31:16]} + {16'h0000, acc[15:0]};
    return ~acc[15:0];
endfunction

// Appends the n low bytes of v, MSB first
function automatic void push_be(inout udp_tx_pkg::byte_t q[$], input logic [63:0] v,
                                input int n);
    for (int i = n - 1; i >= 0; i--) begin
        q.push_back(v[8*i +: 8]);
    end
endfunction

function automatic void build_frame(input udp_tx_pkg::mac_t dst_mac,
                                    input udp_tx_pkg::ip_addr_t dst_ip,
                                    input udp_tx_pkg::word_t words[$],
                                    output udp_tx_pkg::byte_t frame[$]);
    logic [15:0]          ip_words[$];
    logic [15:0]          udp_words[$];
    udp_tx_pkg::ip_addr_t src_ip;
    logic [15:0]          udp_len;
    logic [15:0]          ip_len;
    src_ip  = udp_tx_pkg::LOCAL_IP;
    udp_len = 16'(8 + 8 * words.size());
    ip_len  = udp_len + 16'd20;
    ip_words = {16'h4500, ip_len, 16'h0000, 16'h4000, 16'h8011, 16'h0000,
                src_ip[31:16], src_ip[15:0], dst_ip[31:16], dst_ip[15:0]};
    ip_words[5] = ones_csum(ip_words);
    // Pseudo header first, checksum field zero
    udp_words = {src_ip[31:16], src_ip[15:0], dst_ip[31:16], dst_ip[15:0], 16'h0011,
                 udp_len, udp_tx_pkg::LOCAL_SP, udp_tx_pkg::LOCAL_DP, udp_len, 16'h0000};
    foreach (words[w]) begin
        for (int h = 3; h >= 0; h--) udp_words.push_back(words[w][16*h +: 16]);
    end
    frame.delete();
    push_be(frame, dst_mac, 6);
    push_be(frame, udp_tx_pkg::LOCAL_MAC, 6);
    push_be(frame, 64'h0800, 2);
    foreach (ip_words[i]) push_be(frame, ip_words[i], 2);
    push_be(frame, {udp_tx_pkg::LOCAL_SP, udp_tx_pkg::LOCAL_DP, udp_len,
                    ones_csum(udp_words)}, 8);
    foreach (words[w]) push_be(frame, words[w], 8);
endfunction

`endif

//--- testbench/tb_udp_tx.sv
`timescale 1ns/100ps

module tb_udp_tx;

    localparam int NUM_FRAMES = 30;
    localparam int MAX_WORDS  = 16;
    localparam int WAIT_LIMIT = 5000;  // Cycles per wait

    logic                 axi_clk;
    logic                 local_rstn;
    logic                 i_wr_valid;
    udp_tx_pkg::word_t    i_wr_data;
    logic                 i_wr_last;
    udp_tx_pkg::mac_t     i_target_mac;
    udp_tx_pkg::ip_addr_t i_target_ip;
    logic                 i_tready;
    udp_tx_pkg::byte_t    o_tdata;
    logic                 o_tvalid;
    logic                 o_tlast;

    int                seed = 32'hddd2_489c;
    int                ready_seed;
    logic              hold_ready;  // Keeps i_tready high for the frame
    int                errors;
    int                frame_no;
    udp_tx_pkg::byte_t got_bytes[$];
    logic              got_last[$];

    `include "udp_frame_model.svh"

    udp_tx_top udp_tx_top_i (
        .axi_clk      (axi_clk),
        .local_rstn   (local_rstn),
        .i_wr_valid   (i_wr_valid),
        .i_wr_data    (i_wr_data),
        .i_wr_last    (i_wr_last),
        .i_target_mac (i_target_mac),
        .i_target_ip  (i_target_ip),
        .i_tready     (i_tready),
        .o_tdata      (o_tdata),
        .o_tvalid     (o_tvalid),
        .o_tlast      (o_tlast)
    );

    bind frame_sequencer udp_tx_assertions udp_tx_assertions_i (
        .axi_clk    (axi_clk),
        .local_rstn (local_rstn),
        .i_tready   (i_tready),
        .o_tdata    (o_tdata),
        .o_tvalid   (o_tvalid),
        .o_tlast    (o_tlast)
    );

    initial begin
        axi_clk = 1'b0;
        forever #5 axi_clk = ~axi_clk;
    end

    // Consumer stalls on about a third of the cycles
    always @(posedge axi_clk) begin
        i_tready <= hold_ready || ($random(ready_seed) % 3 != 0);
    end

    always @(posedge axi_clk) begin
        if (local_rstn && o_tvalid && i_tready) begin
            got_bytes.push_back(o_tdata);
            got_last.push_back(o_tlast);
        end
    end

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
        fail_run();
    endtask

    task automatic send_words(input udp_tx_pkg::word_t words[$]);
        int gap;
        foreach (words[i]) begin
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                @(posedge axi_clk);
                i_wr_valid <= 1'b0;
            end
            @(posedge axi_clk);
            i_wr_valid <= 1'b1;
            i_wr_data  <= words[i];
            i_wr_last  <= (i == words.size() - 1);
        end
    endtask

    // Cycles from the last word to o_tvalid
    task automatic wait_tvalid(output int lat);
        lat = 0;
        do begin
            @(posedge axi_clk);
            i_wr_valid <= 1'b0;
            i_wr_last  <= 1'b0;
            lat++;
            @(negedge axi_clk);
        end while (!o_tvalid && lat < WAIT_LIMIT);
        if (!o_tvalid) report_timeout("o_tvalid to rise");
    endtask

    task automatic wait_frame_end();
        int cycles;
        cycles = 0;
        while (!(got_last.size() > 0 && got_last[$]) && cycles < WAIT_LIMIT) begin
            @(negedge axi_clk);
            cycles++;
        end
        if (!(got_last.size() > 0 && got_last[$])) report_timeout("the last byte of a frame");
    endtask

    initial begin
        udp_tx_pkg::word_t    words[$];
        udp_tx_pkg::byte_t    expected[$];
        udp_tx_pkg::mac_t     mac;
        udp_tx_pkg::ip_addr_t ip;
        int                   n_words;
        int                   lat;
        errors       = 0;
        ready_seed   = seed ^ 32'h1357_9bdf;
        hold_ready   = 1'b1;
        local_rstn   = 1'b0;
        i_wr_valid   = 1'b0;
        i_wr_data    = '0;
        i_wr_last    = 1'b0;
        i_target_mac = '0;
        i_target_ip  = '0;
        i_tready     = 1'b0;
        repeat (4) @(posedge axi_clk);
        local_rstn <= 1'b1;
        for (frame_no = 0; frame_no < NUM_FRAMES; frame_no++) begin
            @(negedge axi_clk);
            hold_ready = (frame_no % 3 == 0);
            got_bytes.delete();
            got_last.delete();
            words.delete();
            n_words = 1 + {$random(seed)} % MAX_WORDS;
            repeat (n_words) words.push_back({$random(seed), $random(seed)});
            mac = {16'($random(seed)), 32'($random(seed))};
            ip  = $random(seed);
            build_frame(mac, ip, words, expected);
            @(posedge axi_clk);
            i_target_mac <= mac;
            i_target_ip  <= ip;
            send_words(words);
            wait_tvalid(lat);
            if (hold_ready) check_value(lat, 5, $sformatf("frame %0d tvalid latency", frame_no));
            wait_frame_end();
            check_value(got_bytes.size(), expected.size(),
                        $sformatf("frame %0d byte count", frame_no));
            foreach (expected[i]) begin
                check_value(got_bytes[i], expected[i], $sformatf("frame %0d byte %0d", frame_no, i));
                check_value(got_last[i], i == expected.size() - 1,
                            $sformatf("frame %0d tlast at byte %0d", frame_no, i));
            end
            check_value(udp_tx_top_i.frame_sequencer_i.udp_tx_assertions_i.fail_cnt, 0,
                        $sformatf("frame %0d protocol assertion count", frame_no));
        end
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/udp_tx_assertions.sv
`timescale 1ns/100ps

module udp_tx_assertions (
    input logic              axi_clk,
    input logic              local_rstn,
    input logic              i_tready,
    input udp_tx_pkg::byte_t o_tdata,
    input logic              o_tvalid,
    input logic              o_tlast
);

    int fail_cnt = 0;  // Failures seen so far

    // Stalled byte holds until accepted
    stall_hold: assert property (@(posedge axi_clk) disable iff (!local_rstn)
        o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
        else begin
            $error("output byte or tlast changed while stalled");
            fail_cnt++;
        end

    last_needs_valid: assert property (@(posedge axi_clk) disable iff (!local_rstn)
        o_tlast |-> o_tvalid)
        else begin
            $error("tlast high without tvalid");
            fail_cnt++;
        end

    valid_after_reset: assert property (@(posedge axi_clk) !local_rstn |=> !o_tvalid)
        else begin
            $error("tvalid high in the cycle after reset");
            fail_cnt++;
        end

endmodule

//--- logic/udp_tx_top.sv
`timescale 1ns/100ps

module udp_tx_top (
    input  logic                 axi_clk,
    input  logic                 local_rstn,
    input  logic                 i_wr_valid,
    input  udp_tx_pkg::word_t    i_wr_data,
    input  logic                 i_wr_last,
    input  udp_tx_pkg::mac_t     i_target_mac,
    input  udp_tx_pkg::ip_addr_t i_target_ip,
    input  logic                 i_tready,
    output udp_tx_pkg::byte_t    o_tdata,
    output logic                 o_tvalid,
    output logic                 o_tlast
);

    // Frame summary from the accumulator
    logic              frame_ready;
    udp_tx_pkg::len_t  acc_ip_len;
    udp_tx_pkg::len_t  acc_udp_len;
    udp_tx_pkg::sum_t  data_sum;

    // Finished header values
    logic              hdr_valid;
    udp_tx_pkg::csum_t ip_csum;
    udp_tx_pkg::csum_t udp_csum;
    udp_tx_pkg::len_t  hdr_ip_len;
    udp_tx_pkg::len_t  hdr_udp_len;

    logic              fifo_pop;
    udp_tx_pkg::word_t fifo_data;
    logic              fifo_last;

    payload_fifo payload_fifo_i (
        .axi_clk    (axi_clk),
        .local_rstn (local_rstn),
        .i_wr_valid (i_wr_valid),
        .i_wr_data  (i_wr_data),
        .i_wr_last  (i_wr_last),
        .i_pop      (fifo_pop),
        .o_data     (fifo_data),
        .o_last     (fifo_last)
    );

    payload_accum payload_accum_i (
        .axi_clk       (axi_clk),
        .local_rstn    (local_rstn),
        .i_wr_valid    (i_wr_valid),
        .i_wr_data     (i_wr_data),
        .i_wr_last     (i_wr_last),
        .o_frame_ready (frame_ready),
        .o_ip_len      (acc_ip_len),
        .o_udp_len     (acc_udp_len),
        .o_data_sum    (data_sum)
    );

    header_checksum header_checksum_i (
        .axi_clk       (axi_clk),
        .local_rstn    (local_rstn),
        .i_frame_ready (frame_ready),
        .i_ip_len      (acc_ip_len),
        .i_udp_len     (acc_udp_len),
        .i_data_sum    (data_sum),
        .i_target_ip   (i_target_ip),
        .o_hdr_valid   (hdr_valid),
        .o_ip_csum     (ip_csum),
        .o_udp_csum    (udp_csum),
        .o_ip_len      (hdr_ip_len),
        .o_udp_len     (hdr_udp_len)
    );

    frame_sequencer frame_sequencer_i (
        .axi_clk      (axi_clk),
        .local_rstn   (local_rstn),
        .i_hdr_valid  (hdr_valid),
        .i_ip_csum    (ip_csum),
        .i_udp_csum   (udp_csum),
        .i_ip_len     (hdr_ip_len),
        .i_udp_len    (hdr_udp_len),
        .i_target_mac (i_target_mac),
        .i_target_ip  (i_target_ip),
        .i_fifo_data  (fifo_data),
        .i_fifo_last  (fifo_last),
        .o_fifo_pop   (fifo_pop),
        .i_tready     (i_tready),
        .o_tdata      (o_tdata),
        .o_tvalid     (o_tvalid),
        .o_tlast      (o_tlast)
    );

endmodule

//--- logic/frame_sequencer.sv
`timescale 1ns/100ps

module frame_sequencer (
    input  logic                 axi_clk,
    input  logic                 local_rstn,
    input  logic                 i_hdr_valid,
    input  udp_tx_pkg::csum_t    i_ip_csum,
    input  udp_tx_pkg::csum_t    i_udp_csum,
    input  udp_tx_pkg::len_t     i_ip_len,
    input  udp_tx_pkg::len_t     i_udp_len,
    input  udp_tx_pkg::mac_t     i_target_mac,
    input  udp_tx_pkg::ip_addr_t i_target_ip,
    input  udp_tx_pkg::word_t    i_fifo_data,
    input  logic                 i_fifo_last,
    output logic                 o_fifo_pop,
    input  logic                 i_tready,
    output udp_tx_pkg::byte_t    o_tdata,
    output logic                 o_tvalid,
    output logic                 o_tlast
);

    // State and counters describe the byte held in o_tdata
    udp_tx_pkg::tx_state_t  state;
    udp_tx_pkg::tx_state_t  nxt_state;
    udp_tx_pkg::octet_cnt_t cnt;
    udp_tx_pkg::octet_cnt_t nxt_cnt;
    logic [2:0]             idx;      // Byte 0 is the word MSB
    logic [2:0]             nxt_idx;
    udp_tx_pkg::byte_t      nxt_byte;
    logic                   handshake;
    logic                   load;

    logic [111:0] eth_hdr;
    logic [159:0] ip_hdr;
    logic [63:0]  udp_hdr;

    assign eth_hdr = {i_target_mac, udp_tx_pkg::LOCAL_MAC, udp_tx_pkg::ETH_TYPE_IP};
    assign ip_hdr  = {udp_tx_pkg::IP_VER_TOS, i_ip_len, udp_tx_pkg::IP_IDENT,
                      udp_tx_pkg::IP_FLAG_OFFSET, udp_tx_pkg::IP_TTL_PROTO, i_ip_csum,
                      udp_tx_pkg::LOCAL_IP, i_target_ip};
    assign udp_hdr = {udp_tx_pkg::LOCAL_SP, udp_tx_pkg::LOCAL_DP, i_udp_len, i_udp_csum};

    assign handshake = o_tvalid && i_tready;
    // Frame start, or advance to the following byte
    assign load = (state == udp_tx_pkg::IDLE && i_hdr_valid) || (handshake && !o_tlast);

    // Word leaves the FIFO once its last byte sits in the output register
    assign o_fifo_pop = handshake && state == udp_tx_pkg::UDP_DATA && idx == 3'd6;

    always_comb begin
        nxt_state = state;
        nxt_cnt   = cnt;
        nxt_idx   = idx;
        case (state)
            udp_tx_pkg::IDLE: begin
                nxt_state = udp_tx_pkg::ETH_HEAD;
                nxt_cnt   = '0;
            end
            udp_tx_pkg::ETH_HEAD: begin
                if (cnt == udp_tx_pkg::octet_cnt_t'(udp_tx_pkg::ETH_HEAD_LEN - 1)) begin
                    nxt_state = udp_tx_pkg::IP_HEAD;
                    nxt_cnt   = '0;
                end else begin
                    nxt_cnt = cnt + 1'b1;
                end
            end
            udp_tx_pkg::IP_HEAD: begin
                if (cnt == udp_tx_pkg::octet_cnt_t'(udp_tx_pkg::IP_HEAD_LEN - 1)) begin
                    nxt_state = udp_tx_pkg::UDP_HEAD;
                    nxt_cnt   = '0;
                end else begin
                    nxt_cnt = cnt + 1'b1;
                end
            end
            udp_tx_pkg::UDP_HEAD: begin
                if (cnt == udp_tx_pkg::octet_cnt_t'(udp_tx_pkg::UDP_HEAD_LEN - 1)) begin
                    nxt_state = udp_tx_pkg::UDP_DATA;
                    nxt_idx   = '0;
                end else begin
                    nxt_cnt = cnt + 1'b1;
                end
            end
            udp_tx_pkg::UDP_DATA: nxt_idx = idx + 3'd1;  // Wraps into the next word
            default:              nxt_state = udp_tx_pkg::IDLE;
        endcase
    end

    // Byte at the next position, header fields sent MSB first
    always_comb begin
        case (nxt_state)
            udp_tx_pkg::ETH_HEAD: nxt_byte = eth_hdr[8*(13 - nxt_cnt) +: 8];
            udp_tx_pkg::IP_HEAD:  nxt_byte = ip_hdr[8*(19 - nxt_cnt) +: 8];
            udp_tx_pkg::UDP_HEAD: nxt_byte = udp_hdr[8*(7 - nxt_cnt) +: 8];
            udp_tx_pkg::UDP_DATA: nxt_byte = i_fifo_data[8*(7 - nxt_idx) +: 8];
            default:              nxt_byte = '0;
        endcase
    end

    always_ff @(posedge axi_clk) begin
        if (!local_rstn) begin
            state    <= udp_tx_pkg::IDLE;
            cnt      <= '0;
            idx      <= '0;
            o_tvalid <= 1'b0;
            o_tlast  <= 1'b0;
        end else if (handshake && o_tlast) begin
            state    <= udp_tx_pkg::IDLE;  // Frame done
            o_tvalid <= 1'b0;
            o_tlast  <= 1'b0;
        end else if (load) begin
            state    <= nxt_state;
            cnt      <= nxt_cnt;
            idx      <= nxt_idx;
            o_tvalid <= 1'b1;
            // Head word is still the current one here
            o_tlast  <= nxt_state == udp_tx_pkg::UDP_DATA && nxt_idx == 3'd7 && i_fifo_last;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (load) begin
            o_tdata <= nxt_byte;
        end
    end

endmodule

//--- logic/header_checksum.sv
`timescale 1ns/100ps

module header_checksum (
    input  logic                 axi_clk,
    input  logic                 local_rstn,
    input  logic                 i_frame_ready,
    input  udp_tx_pkg::len_t     i_ip_len,
    input  udp_tx_pkg::len_t     i_udp_len,
    input  udp_tx_pkg::sum_t     i_data_sum,
    input  udp_tx_pkg::ip_addr_t i_target_ip,
    output logic                 o_hdr_valid,
    output udp_tx_pkg::csum_t    o_ip_csum,
    output udp_tx_pkg::csum_t    o_udp_csum,
    output udp_tx_pkg::len_t     o_ip_len,
    output udp_tx_pkg::len_t     o_udp_len
);

    // 0 idle, 1 sums loaded, 2 folded once
    logic [1:0]       step;
    udp_tx_pkg::sum_t ip_acc;
    udp_tx_pkg::sum_t udp_acc;
    udp_tx_pkg::sum_t target_sum;

    // End-around carry of the upper half into the lower half
    function automatic udp_tx_pkg::sum_t fold(input udp_tx_pkg::sum_t s);
        return udp_tx_pkg::sum_t'(s[31:16]) + udp_tx_pkg::sum_t'(s[15:0]);
    endfunction

    assign target_sum = udp_tx_pkg::sum_t'(i_target_ip[31:16])
                      + udp_tx_pkg::sum_t'(i_target_ip[15:0]);

    always_ff @(posedge axi_clk) begin
        if (!local_rstn) begin
            step        <= 2'd0;
            o_hdr_valid <= 1'b0;
        end else begin
            o_hdr_valid <= (step == 2'd2);
            if (i_frame_ready) begin
                step <= 2'd1;
            end else if (step == 2'd2) begin
                step <= 2'd0;
            end else if (step != 2'd0) begin
                step <= step + 2'd1;
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (i_frame_ready) begin
            ip_acc  <= udp_tx_pkg::IP_LOCAL_SUM + target_sum + udp_tx_pkg::sum_t'(i_ip_len);
            // UDP length counts twice, pseudo header and UDP header
            udp_acc <= udp_tx_pkg::UDP_LOCAL_SUM + target_sum + i_data_sum
                     + (udp_tx_pkg::sum_t'(i_udp_len) << 1);
        end else if (step == 2'd1) begin
            ip_acc  <= fold(ip_acc);
            udp_acc <= fold(udp_acc);
        end else if (step == 2'd2) begin
            o_ip_csum  <= ~udp_tx_pkg::csum_t'(fold(ip_acc));
            o_udp_csum <= ~udp_tx_pkg::csum_t'(fold(udp_acc));
            o_ip_len   <= i_ip_len;
            o_udp_len  <= i_udp_len;
        end
    end

endmodule

//--- logic/payload_accum.sv
`timescale 1ns/100ps

module payload_accum (
    input  logic              axi_clk,
    input  logic              local_rstn,
    input  logic              i_wr_valid,
    input  udp_tx_pkg::word_t i_wr_data,
    input  logic              i_wr_last,
    output logic              o_frame_ready,
    output udp_tx_pkg::len_t  o_ip_len,
    output udp_tx_pkg::len_t  o_udp_len,
    output udp_tx_pkg::sum_t  o_data_sum
);

    udp_tx_pkg::sum_t word_sum;     // Halves of the incoming word
    udp_tx_pkg::sum_t data_sum;
    udp_tx_pkg::len_t byte_cnt;
    udp_tx_pkg::len_t frame_bytes;  // Payload bytes including this word
    udp_tx_pkg::len_t udp_len;

    always_comb begin
        word_sum = '0;
        for (int h = 0; h < udp_tx_pkg::HALVES_PER_WORD; h++) begin
            word_sum = word_sum + udp_tx_pkg::sum_t'(i_wr_data[16*h +: 16]);
        end
    end

    assign frame_bytes = byte_cnt + udp_tx_pkg::len_t'(udp_tx_pkg::WORD_BYTES);
    assign udp_len     = frame_bytes + udp_tx_pkg::UDP_HEAD_LEN;

    always_ff @(posedge axi_clk) begin
        if (!local_rstn) begin
            data_sum      <= '0;
            byte_cnt      <= '0;
            o_frame_ready <= 1'b0;
        end else begin
            o_frame_ready <= i_wr_valid && i_wr_last;
            if (i_wr_valid && i_wr_last) begin
                data_sum <= '0;  // Ready for next frame
                byte_cnt <= '0;
            end else if (i_wr_valid) begin
                data_sum <= data_sum + word_sum;
                byte_cnt <= frame_bytes;
            end
        end
    end

    // Frame summary, held until the next last word
    always_ff @(posedge axi_clk) begin
        if (i_wr_valid && i_wr_last) begin
            o_udp_len  <= udp_len;
            o_ip_len   <= udp_len + udp_tx_pkg::IP_HEAD_LEN;
            o_data_sum <= data_sum + word_sum;
        end
    end

endmodule

//--- logic/payload_fifo.sv
`timescale 1ns/100ps

module payload_fifo (
    input  logic              axi_clk,
    input  logic              local_rstn,
    input  logic              i_wr_valid,
    input  udp_tx_pkg::word_t i_wr_data,
    input  logic              i_wr_last,
    input  logic              i_pop,
    output udp_tx_pkg::word_t o_data,
    output logic              o_last
);

    // Storage, one entry per payload word
    udp_tx_pkg::word_t data_mem [udp_tx_pkg::PAYLOAD_MAX_WORDS];
    logic              last_mem [udp_tx_pkg::PAYLOAD_MAX_WORDS];

    logic [udp_tx_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [udp_tx_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;

    // Pointers wrap at the depth
    always_ff @(posedge axi_clk) begin
        if (!local_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (i_wr_valid) begin
            data_mem[wr_ptr] <= i_wr_data;
            last_mem[wr_ptr] <= i_wr_last;
        end
    end

    // Head word visible without a read cycle
    assign o_data = data_mem[rd_ptr];
    assign o_last = last_mem[rd_ptr];

endmodule

//--- logic/udp_tx_pkg.sv
package udp_tx_pkg;

    // Payload geometry
    localparam int DATA_WIDTH        = 64;
    localparam int WORD_BYTES        = 8;
    localparam int HALVES_PER_WORD   = 4;
    localparam int PAYLOAD_MAX_WORDS = 128;  // 1024 bytes, also FIFO depth
    localparam int FIFO_ADDR_WIDTH   = 7;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [47:0]           mac_t;
    typedef logic [31:0]           ip_addr_t;
    typedef logic [15:0]           len_t;
    typedef logic [31:0]           sum_t;
    typedef logic [15:0]           csum_t;
    typedef logic [7:0]            byte_t;
    typedef logic [4:0]            octet_cnt_t;

    typedef enum logic [2:0] {IDLE, ETH_HEAD, IP_HEAD, UDP_HEAD, UDP_DATA} tx_state_t;

    // Fixed station identity
    localparam mac_t        LOCAL_MAC = 48'hABCD_1234_5678;
    localparam ip_addr_t    LOCAL_IP  = 32'hC0A8_006E;
    localparam logic [15:0] LOCAL_SP  = 16'd8080;
    localparam logic [15:0] LOCAL_DP  = 16'd8080;

    localparam logic [15:0] ETH_TYPE_IP    = 16'h0800;
    localparam logic [15:0] IP_VER_TOS     = 16'h4500;  // IPv4, IHL 5, TOS 0
    localparam logic [15:0] IP_FLAG_OFFSET = 16'h4000;  // Don't fragment
    localparam logic [15:0] IP_TTL_PROTO   = 16'h8011;  // TTL 0x80, UDP
    localparam logic [15:0] IP_IDENT       = 16'h0000;
    localparam logic [15:0] UDP_PROTO      = 16'h0011;

    localparam len_t ETH_HEAD_LEN = 16'd14;
    localparam len_t IP_HEAD_LEN  = 16'd20;
    localparam len_t UDP_HEAD_LEN = 16'd8;

    // Constant parts of the checksums
    localparam sum_t IP_LOCAL_SUM = sum_t'(IP_VER_TOS) + sum_t'(IP_IDENT)
                                  + sum_t'(IP_FLAG_OFFSET) + sum_t'(IP_TTL_PROTO)
                                  + sum_t'(LOCAL_IP[31:16]) + sum_t'(LOCAL_IP[15:0]);
    // Pseudo header source address and protocol, plus both ports
    localparam sum_t UDP_LOCAL_SUM = sum_t'(LOCAL_IP[31:16]) + sum_t'(LOCAL_IP[15:0])
                                   + sum_t'(UDP_PROTO) + sum_t'(LOCAL_SP)
                                   + sum_t'(LOCAL_DP);

endpackage
